//--- Makefile
# Verilator lint and simulation of the Huffman ISM dump path

VERILATOR  ?= verilator
TOP        ?= tb_huf_ism_top
FILELIST   ?= huf_ism_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ** PASS **
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- huf_ism_top.f
logic/huf_ism_pkg.sv
logic/huf_depth_table.sv
logic/huf_ism_catcher.sv
logic/huf_ism_drain.sv
logic/huf_ism_top.sv
test/tb_clock_gen.sv
test/tb_huf_ism_top.sv

//--- logic/huf_depth_table.sv
//--------------------------------------
// Writes to a lane are dropped from block end until its dump is done
// A BLK_END for a lane that is still held is ignored
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module huf_depth_table
(
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  huf_ism_pkg::depth_wr_t                   depth_wr,
  input  huf_ism_pkg::blk_evt_t                    blk_evt,
  input  logic [huf_ism_pkg::NUM_LANES-1:0]        done,
  output logic [huf_ism_pkg::NUM_LANES-1:0]
               [huf_ism_pkg::NUM_SYM-1:0]
               [huf_ism_pkg::CL_W-1:0]             sym_dpth,
  output huf_ism_pkg::blk_info_t [huf_ism_pkg::NUM_LANES-1:0] blk_info,
  output logic [huf_ism_pkg::NUM_LANES-1:0]        start,
  output logic [huf_ism_pkg::NUM_LANES-1:0]        lane_busy
);
  import huf_ism_pkg::*;

  logic [NUM_LANES-1:0][NUM_SYM-1:0][CL_W-1:0] tbl;
  blk_info_t [NUM_LANES-1:0]                   info_q;
  logic [NUM_LANES-1:0]                        hold;
  logic [NUM_LANES-1:0]                        start_q;
  logic [NUM_LANES-1:0]                        blk_end;

  // Middle and pass-through marks never start a dump
  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      blk_end[l] = blk_evt.vld && (blk_evt.mark == BLK_END) &&
                   (blk_evt.lane == LANE_W'(l)) && !hold[l];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tbl <= '0;
    end
    else if (depth_wr.wr && !hold[depth_wr.lane])
    begin
      tbl[depth_wr.lane][depth_wr.sym] <= depth_wr.len;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold    <= '0;
      start_q <= '0;
    end
    else
    begin
      hold    <= (hold | blk_end) & ~done;
      start_q <= blk_end;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (blk_end[l])
      begin
        info_q[l].seq_id       <= blk_evt.seq_id;
        info_q[l].zero_symbols <= blk_evt.zero_symbols;
        info_q[l].build_error  <= blk_evt.build_error;
      end
    end
  end

  assign sym_dpth  = tbl;
  assign blk_info  = info_q;
  assign start     = start_q;
  assign lane_busy = hold;

  // A catcher is only started on a locked table
  a_start_held: assert property (@(posedge clk) disable iff (!rst_n)
    (start_q & ~hold) == '0);

endmodule

`default_nettype wire

//--- logic/huf_ism_catcher.sv
//--------------------------------------
// sym_dpth and blk_info must hold still from start until done
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module huf_ism_catcher
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [huf_ism_pkg::NUM_SYM-1:0]
               [huf_ism_pkg::CL_W-1:0]           sym_dpth,
  input  huf_ism_pkg::blk_info_t                 blk_info,
  input  logic                                   start,
  input  logic                                   sw_ism_on,
  input  logic                                   lane_rdy,
  input  logic [huf_ism_pkg::LANE_W-1:0]         lane_id,
  output huf_ism_pkg::ism_word_t                 word,
  output logic                                   busy,
  output logic                                   done
);
  import huf_ism_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RDY,
    WR
  } e_catch_state;

  e_catch_state                       state;
  e_catch_state                       state_nxt;
  logic [$clog2(WORDS_PER_TBL)-1:0]   ptr;
  logic [$clog2(WORDS_PER_TBL)-1:0]   ptr_nxt;
  logic [SYM_W-1:0]                   sym_idx;
  logic                               last_word;
  logic                               flagged;
  ism_word_t                          word_nxt;
  ism_word_t                          word_q;
  logic                               done_nxt;
  logic                               done_q;

  assign last_word = (int'(ptr) == WORDS_PER_TBL - 1);
  assign flagged   = blk_info.zero_symbols || blk_info.build_error;

  always_comb
  begin
    state_nxt     = state;
    ptr_nxt       = ptr;
    sym_idx       = '0;
    done_nxt      = 1'b0;
    word_nxt      = '0;
    word_nxt.lane = lane_id;

    case (state)
      IDLE:
      begin
        ptr_nxt = '0;
        if (start)
        begin
          if (sw_ism_on)
            state_nxt = RDY;
          else
            done_nxt = 1'b1;
        end
      end

      RDY:
      begin
        if (lane_rdy)
        begin
          // A flagged block skips the table and sends only the end word
          if (flagged)
          begin
            word_nxt.vld         = 1'b1;
            word_nxt.eob         = 1'b1;
            word_nxt.no_sym      = blk_info.zero_symbols;
            word_nxt.build_error = blk_info.build_error;
            word_nxt.seq_id      = 8'(blk_info.seq_id);
            done_nxt             = 1'b1;
            state_nxt            = IDLE;
          end
          else
          begin
            state_nxt = WR;
          end
        end
      end

      WR:
      begin
        if (lane_rdy)
        begin
          word_nxt.vld = 1'b1;
          for (int i = 0; i < SYM_PER_WORD; i++)
          begin
            sym_idx = SYM_W'(int'(ptr) * SYM_PER_WORD + i);
            word_nxt.data[i*ISM_CL_W +: ISM_CL_W] = ISM_CL_W'(sym_dpth[sym_idx]);
          end
          ptr_nxt = ptr + 1'b1;
          if (last_word)
          begin
            word_nxt.eob    = 1'b1;
            word_nxt.seq_id = 8'(blk_info.seq_id);
            done_nxt        = 1'b1;
            state_nxt       = IDLE;
          end
        end
        else
        begin
          // Ready dropped, wait in RDY and resume at the same pointer
          state_nxt = RDY;
        end
      end

      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= IDLE;
      ptr    <= '0;
      word_q <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      ptr    <= ptr_nxt;
      word_q <= word_nxt;
      done_q <= done_nxt;
    end
  end

  assign word = word_q;
  assign busy = (state != IDLE);
  assign done = done_q;

  a_no_word_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
    word_q.vld |-> $past(state) != IDLE);

  a_eob_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
    word_q.eob |-> word_q.vld);

endmodule

`default_nettype wire

//--- logic/huf_ism_drain.sv
//--------------------------------------
// One lane owns the ISM port from its first word to its eob word
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module huf_ism_drain
(
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  huf_ism_pkg::ism_word_t [huf_ism_pkg::NUM_LANES-1:0] lane_word,
  input  logic [huf_ism_pkg::NUM_LANES-1:0]                  lane_busy,
  input  logic                                               ism_rdy,
  output logic [huf_ism_pkg::NUM_LANES-1:0]                  lane_rdy,
  output huf_ism_pkg::ism_word_t                             ism_word
);
  import huf_ism_pkg::*;

  logic [LANE_W-1:0] grant;
  logic [LANE_W-1:0] grant_nxt;
  logic [LANE_W-1:0] cand;
  logic              move;

  // The owner gives up the port once it is idle or its dump has ended
  assign move = !lane_busy[grant] || (lane_word[grant].vld && lane_word[grant].eob);

  always_comb
  begin
    grant_nxt = grant;
    cand      = grant;
    if (move)
    begin
      // Walk downwards so the nearest busy lane after the owner wins
      for (int i = NUM_LANES - 1; i > 0; i--)
      begin
        cand = grant + LANE_W'(i);
        if (lane_busy[cand])
          grant_nxt = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grant <= '0;
    end
    else
    begin
      grant <= grant_nxt;
    end
  end

  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      lane_rdy[l] = ism_rdy && (grant == LANE_W'(l));
    end
  end

  assign ism_word = lane_word[grant];

  a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(lane_rdy));

  // A catcher word is always the answer to a ready it was given
  for (genvar l = 0; l < NUM_LANES; l++)
  begin : g_chk
    a_word_after_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      lane_word[l].vld |-> $past(lane_rdy[l]));
  end

endmodule

`default_nettype wire

//--- logic/huf_ism_pkg.sv
//--------------------------------------
// Lane count must be a power of two so that lane indices wrap
// NUM_SYM must be a multiple of SYM_PER_WORD
//--------------------------------------
`default_nettype none

package huf_ism_pkg;

  localparam int NUM_LANES     = 4;
  localparam int LANE_W        = 2;
  localparam int NUM_SYM       = 32;
  localparam int SYM_W         = 5;
  localparam int CL_W          = 5;
  localparam int ISM_CL_W      = 8;
  localparam int ISM_DATA_W    = 64;
  localparam int SYM_PER_WORD  = ISM_DATA_W / ISM_CL_W;
  localparam int WORDS_PER_TBL = NUM_SYM / SYM_PER_WORD;
  localparam int SEQ_W         = 6;

  typedef enum logic [1:0] {
    BLK_MIDDLE,
    BLK_END,
    BLK_PASS_THRU
  } e_blk_mark;

  typedef struct packed {
    logic              wr;
    logic [LANE_W-1:0] lane;
    logic [SYM_W-1:0]  sym;
    logic [CL_W-1:0]   len;
  } depth_wr_t;

  typedef struct packed {
    logic              vld;
    logic [LANE_W-1:0] lane;
    e_blk_mark         mark;
    logic [SEQ_W-1:0]  seq_id;
    logic              zero_symbols;
    logic              build_error;
  } blk_evt_t;

  typedef struct packed {
    logic [SEQ_W-1:0] seq_id;
    logic             zero_symbols;
    logic             build_error;
  } blk_info_t;

  // The ISM port carries an 8-bit sequence id
  typedef struct packed {
    logic                  vld;
    logic [LANE_W-1:0]     lane;
    logic [ISM_DATA_W-1:0] data;
    logic                  eob;
    logic                  no_sym;
    logic                  build_error;
    logic [7:0]            seq_id;
  } ism_word_t;

endpackage

`default_nettype wire

//--- logic/huf_ism_top.sv
//--------------------------------------
// ism_rdy is a plain level, a word follows it by one cycle
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module huf_ism_top
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  huf_ism_pkg::depth_wr_t            depth_wr,
  input  huf_ism_pkg::blk_evt_t             blk_evt,
  input  logic                              sw_ism_on,
  input  logic                              ism_rdy,
  output huf_ism_pkg::ism_word_t            ism_word,
  output logic [huf_ism_pkg::NUM_LANES-1:0] lane_busy
);
  import huf_ism_pkg::*;

  logic [NUM_LANES-1:0][NUM_SYM-1:0][CL_W-1:0] sym_dpth;
  blk_info_t [NUM_LANES-1:0]                   blk_info;
  logic [NUM_LANES-1:0]                        start;
  logic [NUM_LANES-1:0]                        done;
  logic [NUM_LANES-1:0]                        cat_busy;
  logic [NUM_LANES-1:0]                        lane_rdy;
  ism_word_t [NUM_LANES-1:0]                   lane_word;

  huf_depth_table u_table
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .depth_wr  (depth_wr),
    .blk_evt   (blk_evt),
    .done      (done),
    .sym_dpth  (sym_dpth),
    .blk_info  (blk_info),
    .start     (start),
    .lane_busy (lane_busy)
  );

  for (genvar l = 0; l < NUM_LANES; l++)
  begin : g_catcher
    huf_ism_catcher u_catcher
    (
      .clk       (clk),
      .rst_n     (rst_n),
      .sym_dpth  (sym_dpth[l]),
      .blk_info  (blk_info[l]),
      .start     (start[l]),
      .sw_ism_on (sw_ism_on),
      .lane_rdy  (lane_rdy[l]),
      .lane_id   (LANE_W'(l)),
      .word      (lane_word[l]),
      .busy      (cat_busy[l]),
      .done      (done[l])
    );
  end

  huf_ism_drain u_drain
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .lane_word (lane_word),
    .lane_busy (cat_busy),
    .ism_rdy   (ism_rdy),
    .lane_rdy  (lane_rdy),
    .ism_word  (ism_word)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
//----------------------------------------
// 40 ns clock, reset released on a falling edge after 16 cycles
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_huf_ism_top.sv
//----------------------------------------
// Inputs change and outputs are sampled on falling edges only
// The model follows lane_busy to decide which writes land
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_huf_ism_top;
  import huf_ism_pkg::*;

  logic                 clk;
  logic                 rst_n;
  depth_wr_t            depth_wr;
  blk_evt_t             blk_evt;
  logic                 sw_ism_on;
  logic                 ism_rdy;
  ism_word_t            ism_word;
  logic [NUM_LANES-1:0] lane_busy;

  logic [31:0]          rng;
  depth_wr_t            wr_req;
  blk_evt_t             evt_req;
  logic                 sw_req;
  int                   rdy_pct;
  int                   wr_pct;
  int                   err_cnt;
  int                   test_cnt;
  int                   fail_cnt;
  int                   test_err0;
  int                   owner;
  logic [CL_W-1:0]      shadow [NUM_LANES][NUM_SYM];
  ism_word_t            exp_q [NUM_LANES][$];
  logic [NUM_LANES-1:0] end_pend;
  blk_info_t            pend_info [NUM_LANES];

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  huf_ism_top dut
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .depth_wr  (depth_wr),
    .blk_evt   (blk_evt),
    .sw_ism_on (sw_ism_on),
    .ism_rdy   (ism_rdy),
    .ism_word  (ism_word),
    .lane_busy (lane_busy)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift32(rng);
    return int'(rng % 32'(n));
  endfunction

  function automatic logic queues_empty();
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (exp_q[l].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report_mismatch(input string name, input int l,
                                 input logic [ISM_DATA_W-1:0] got,
                                 input logic [ISM_DATA_W-1:0] exp);
    $display("Mismatch ism_word.%s on lane %0d: got 0x%h, expected 0x%h", name, l, got, exp);
    err_cnt++;
  endtask

  // Expected words of one dump, built from the shadow table that is locked by now
  task automatic queue_dump(input int l);
    ism_word_t w;
    w      = '0;
    w.vld  = 1'b1;
    w.lane = LANE_W'(l);
    if (pend_info[l].zero_symbols || pend_info[l].build_error)
    begin
      w.eob         = 1'b1;
      w.no_sym      = pend_info[l].zero_symbols;
      w.build_error = pend_info[l].build_error;
      w.seq_id      = 8'(pend_info[l].seq_id);
      exp_q[l].push_back(w);
    end
    else
    begin
      for (int k = 0; k < WORDS_PER_TBL; k++)
      begin
        for (int i = 0; i < SYM_PER_WORD; i++)
          w.data[i*ISM_CL_W +: ISM_CL_W] = ISM_CL_W'(shadow[l][k*SYM_PER_WORD + i]);
        w.eob    = (k == WORDS_PER_TBL - 1);
        w.seq_id = w.eob ? 8'(pend_info[l].seq_id) : 8'h00;
        exp_q[l].push_back(w);
      end
    end
  endtask

  task automatic check_output();
    ism_word_t got;
    ism_word_t exp;
    int        l;
    got = ism_word;
    if (got.vld)
    begin
      l = int'(got.lane);
      if (owner >= 0 && owner != l)
      begin
        $display("Word of lane %0d arrived inside the dump of lane %0d", l, owner);
        err_cnt++;
      end
      owner = got.eob ? -1 : l;
      if (exp_q[l].size() == 0)
      begin
        $display("Unexpected word on lane %0d, no dump was pending there", l);
        err_cnt++;
      end
      else
      begin
        exp = exp_q[l].pop_front();
        if (got.data !== exp.data)
          report_mismatch("data", l, got.data, exp.data);
        if (got.eob !== exp.eob)
          report_mismatch("eob", l, got.eob, exp.eob);
        if (got.no_sym !== exp.no_sym)
          report_mismatch("no_sym", l, got.no_sym, exp.no_sym);
        if (got.build_error !== exp.build_error)
          report_mismatch("build_error", l, got.build_error, exp.build_error);
        if (got.seq_id !== exp.seq_id)
          report_mismatch("seq_id", l, got.seq_id, exp.seq_id);
      end
    end
  endtask

  // One cycle: check the output, drive new inputs, update the model
  task automatic step();
    @(negedge clk);
    check_output();
    sw_ism_on = sw_req;
    ism_rdy   = (rand_below(100) < rdy_pct);
    // The catcher samples sw_ism_on one cycle after the block end
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (end_pend[l] && sw_ism_on)
        queue_dump(l);
    end
    end_pend = '0;
    if (!wr_req.wr && rand_below(100) < wr_pct)
    begin
      wr_req.wr   = 1'b1;
      wr_req.lane = LANE_W'(rand_below(NUM_LANES));
      wr_req.sym  = SYM_W'(rand_below(NUM_SYM));
      wr_req.len  = CL_W'(rand_below(1 << CL_W));
    end
    depth_wr = wr_req;
    blk_evt  = evt_req;
    if (depth_wr.wr && !lane_busy[depth_wr.lane])
      shadow[depth_wr.lane][depth_wr.sym] = depth_wr.len;
    if (blk_evt.vld && blk_evt.mark == BLK_END && !lane_busy[blk_evt.lane])
    begin
      end_pend[blk_evt.lane]               = 1'b1;
      pend_info[blk_evt.lane].seq_id       = blk_evt.seq_id;
      pend_info[blk_evt.lane].zero_symbols = blk_evt.zero_symbols;
      pend_info[blk_evt.lane].build_error  = blk_evt.build_error;
    end
    wr_req  = '0;
    evt_req = '0;
  endtask

  task automatic send_mark(input int l, input e_blk_mark mark, input logic zero,
                           input logic err);
    evt_req.vld          = 1'b1;
    evt_req.lane         = LANE_W'(l);
    evt_req.mark         = mark;
    evt_req.seq_id       = SEQ_W'(rand_below(1 << SEQ_W));
    evt_req.zero_symbols = zero;
    evt_req.build_error  = err;
    step();
  endtask

  task automatic wait_drained(input int limit, input string what);
    int n;
    n = 0;
    while ((end_pend != '0 || lane_busy != '0 || !queues_empty()) && n < limit)
    begin
      step();
      n++;
    end
    if (end_pend != '0 || lane_busy != '0 || !queues_empty())
    begin
      $display("Timeout after %0d cycles waiting for %s", limit, what);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0)
      $display("Test %0d %s: ok", test_cnt, name);
    else
    begin
      fail_cnt++;
      $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  initial
  begin
    int n;
    depth_wr  = '0;
    blk_evt   = '0;
    sw_ism_on = 1'b0;
    ism_rdy   = 1'b0;
    rng       = 32'h2c84;
    wr_req    = '0;
    evt_req   = '0;
    sw_req    = 1'b1;
    rdy_pct   = 100;
    wr_pct    = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    test_err0 = 0;
    owner     = -1;
    end_pend  = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      for (int s = 0; s < NUM_SYM; s++)
        shadow[l][s] = '0;
    end

    n = 0;
    while (!rst_n && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (!rst_n)
    begin
      $display("Reset was never released");
      err_cnt++;
    end
    if (lane_busy !== '0 || ism_word.vld !== 1'b0)
    begin
      $display("Mismatch lane_busy/vld after reset: got 0x%h/0x%h, expected 0x0/0x0",
               lane_busy, ism_word.vld);
      err_cnt++;
    end

    // Fill one table completely and dump it
    for (int s = 0; s < NUM_SYM; s++)
    begin
      wr_req = '{wr: 1'b1, lane: '0, sym: SYM_W'(s), len: CL_W'(rand_below(1 << CL_W))};
      step();
    end
    send_mark(0, BLK_END, 1'b0, 1'b0);
    wait_drained(200, "full dump of lane 0");
    finish_test("full dump");

    send_mark(1, BLK_END, 1'b1, 1'b0);
    send_mark(2, BLK_END, 1'b0, 1'b1);
    wait_drained(200, "flagged end words");
    finish_test("flagged blocks");

    // Hold lane 3 with ready low while writes and other marks arrive
    rdy_pct = 0;
    send_mark(3, BLK_END, 1'b0, 1'b0);
    for (int k = 0; k < 24; k++)
    begin
      wr_req = '{wr: 1'b1, lane: 2'd3, sym: SYM_W'(rand_below(NUM_SYM)), len: CL_W'(k + 1)};
      send_mark(rand_below(NUM_LANES), (k % 2 == 0) ? BLK_MIDDLE : BLK_PASS_THRU,
                1'b0, 1'b0);
      if (!lane_busy[3])
      begin
        $display("Lane 3 was not locked while its dump waited");
        err_cnt++;
      end
    end
    rdy_pct = 100;
    wait_drained(200, "held dump of lane 3");
    send_mark(3, BLK_END, 1'b0, 1'b0);
    wait_drained(200, "second dump of lane 3");
    finish_test("locked writes and ignored marks");

    sw_req = 1'b0;
    send_mark(0, BLK_END, 1'b0, 1'b0);
    step();
    if (!lane_busy[0])
    begin
      $display("Lane 0 did not lock on block end with the dump switched off");
      err_cnt++;
    end
    wait_drained(100, "lane_busy to fall with the dump switched off");
    sw_req = 1'b1;
    finish_test("dump switched off");

    for (int r = 0; r < 12; r++)
    begin
      sw_req  = (rand_below(4) != 0);
      rdy_pct = 30 + rand_below(60);
      wr_pct  = 40;
      for (int l = 0; l < NUM_LANES; l++)
        send_mark(l, BLK_END, rand_below(8) == 0, rand_below(8) == 0);
      for (int k = 0; k < 40; k++)
      begin
        if (rand_below(3) == 0)
          send_mark(rand_below(NUM_LANES), e_blk_mark'(rand_below(3)), 1'b0, 1'b0);
        else
          step();
      end
      wait_drained(3000, "random dumps under back-pressure");
    end
    wr_pct  = 0;
    rdy_pct = 100;
    repeat (20) step();
    finish_test("random back-pressure");

    $display("Tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
